// ==== filelist.f ====
+incdir+hw
+incdir+verif
hw/mem_pkg.sv
hw/load_align.sv
hw/mem_lane.sv
hw/mem_wb_reg.sv
hw/mem_stage.sv
verif/tb_mem_stage.sv

// ==== verif/tb_mem_checks.svh ====
`ifndef TB_MEM_CHECKS_SVH
`define TB_MEM_CHECKS_SVH

logic [31:0] lfsr_state;

// galois lfsr, one step per returned bit
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    logic        out_bit;
    bits = '0;
    for (int k = 0; k < n; k++) begin
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        bits = {bits[30:0], out_bit};
    end
    return bits;
endfunction

function automatic logic is_load_op(input logic [`MEM_ALUOP_W-1:0] op);
    return op inside {`MEM_ALU_LDB, `MEM_ALU_LDBU, `MEM_ALU_LDH,
                      `MEM_ALU_LDHU, `MEM_ALU_LDW, `MEM_ALU_LLW};
endfunction

function automatic logic [`MEM_XLEN-1:0] ref_load(input logic [`MEM_ALUOP_W-1:0] op,
        input logic [1:0] off, input logic [`MEM_XLEN-1:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(word >> {off, 3'b000});
    h = 16'(word >> {off, 3'b000});  // only offsets 0 and 2 are legal
    case (op)
        `MEM_ALU_LDB:               return {{24{b[7]}}, b};
        `MEM_ALU_LDBU:              return {24'h0, b};
        `MEM_ALU_LDH:               return off[0] ? 32'h0 : {{16{h[15]}}, h};
        `MEM_ALU_LDHU:              return off[0] ? 32'h0 : {16'h0, h};
        `MEM_ALU_LDW, `MEM_ALU_LLW: return word;
        default:                    return 32'h0;
    endcase
endfunction

function automatic mem_pkg::reg_write_t exp_wb(input mem_pkg::lane_in_t l,
        input logic [`MEM_XLEN-1:0] word, input logic dok);
    mem_pkg::reg_write_t w;
    w = l.wr;
    if (is_load_op(l.aluop)) begin
        w.data = dok ? ref_load(l.aluop, l.mem_addr[1:0], word) : '0;
    end
    return w;
endfunction

function automatic mem_pkg::commit_t exp_commit(input mem_pkg::lane_in_t l);
    mem_pkg::commit_t c;
    c.valid    = l.valid;
    c.pc       = l.pc;
    c.addr     = l.mem_addr;
    c.exc      = `MEM_EXC_OUT_W'(l.exc) << 1;  // own flag is the low bit
    c.cause[0] = `MEM_EXCEPTION_NOP;
    for (int k = 0; k < `MEM_EXC_IN_W; k++) begin
        c.cause[k+1] = l.cause[k];
    end
    return c;
endfunction

task automatic check_wb(input string name, input mem_pkg::reg_write_t exp,
        input mem_pkg::reg_write_t act);
    if (act !== exp) begin
        fail_stop($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_commit(input string name, input mem_pkg::commit_t exp,
        input mem_pkg::commit_t act);
    if (act !== exp) begin
        fail_stop($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_stop($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    end
endtask

`endif

// ==== verif/tb_mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_mem_stage;

    localparam logic [`MEM_ALUOP_W-1:0] OP_ADD = 8'h10;
    localparam logic [`MEM_ALUOP_W-1:0] OP_OR  = 8'h11;

    typedef struct packed {
        logic [`MEM_ALUOP_W-1:0]  op;
        logic [1:0]               off;
        logic [`MEM_XLEN-1:0]     wdata;
        logic [`MEM_EXC_IN_W-1:0] exc;
    } lane_stim_t;

    typedef struct {
        string      name;
        logic       dok;
        lane_stim_t lane [`MEM_LANES];
    } row_t;

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    mem_pkg::lane_in_t   [`MEM_LANES-1:0] lane_in;
    logic                [`MEM_XLEN-1:0]  dcache_read_data;
    logic                                 data_ok;
    mem_pkg::reg_write_t [`MEM_LANES-1:0] mem_pf_write;
    logic                                 pause_mem;
    mem_pkg::wb_bundle_t                  wb_write;
    mem_pkg::commit_bundle_t              commit_out;

    row_t rows[$];
    logic table_built = 1'b0;

    always #5 clk = ~clk;

    mem_stage i_mem_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_in          (lane_in),
        .dcache_read_data (dcache_read_data),
        .data_ok          (data_ok),
        .mem_pf_write     (mem_pf_write),
        .pause_mem        (pause_mem),
        .wb_write         (wb_write),
        .commit_out       (commit_out)
    );

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_mem_checks.svh"

    function automatic lane_stim_t lane_stim(input logic [`MEM_ALUOP_W-1:0] op,
            input logic [1:0] off, input logic [`MEM_XLEN-1:0] wdata,
            input logic [`MEM_EXC_IN_W-1:0] exc);
        lane_stim_t s;
        s.op    = op;
        s.off   = off;
        s.wdata = wdata;
        s.exc   = exc;
        return s;
    endfunction

    task automatic add_row(input string name, input logic dok, input lane_stim_t a,
            input lane_stim_t b);
        row_t r;
        r.name    = name;
        r.dok     = dok;
        r.lane[0] = a;
        r.lane[1] = b;
        rows.push_back(r);
    endtask

    // random pc, upper address, register and causes around the row's fields
    function automatic mem_pkg::lane_in_t make_lane(input lane_stim_t s);
        mem_pkg::lane_in_t l;
        l.valid    = 1'b1;
        l.pc       = {30'(lfsr_bits(30)), 2'b00};
        l.aluop    = s.op;
        l.mem_addr = {30'(lfsr_bits(30)), s.off};
        l.wr.en    = 1'b1;
        l.wr.addr  = `MEM_REG_AW'(lfsr_bits(`MEM_REG_AW));
        l.wr.data  = s.wdata;
        l.exc      = s.exc;
        for (int c = 0; c < `MEM_EXC_IN_W; c++) begin
            l.cause[c] = `MEM_CAUSE_W'(lfsr_bits(`MEM_CAUSE_W));
        end
        return l;
    endfunction

    task automatic build_table();
        add_row("ldb_ldbu_off0", 1'b1, lane_stim(`MEM_ALU_LDB, 2'd0, 32'h1111_0000, 5'h00),
                lane_stim(`MEM_ALU_LDBU, 2'd0, 32'h2222_0000, 5'h00));
        add_row("ldb_ldbu_off1", 1'b1, lane_stim(`MEM_ALU_LDB, 2'd1, 32'h1111_0001, 5'h00),
                lane_stim(`MEM_ALU_LDBU, 2'd1, 32'h2222_0001, 5'h00));
        add_row("ldbu_ldb_off2", 1'b1, lane_stim(`MEM_ALU_LDBU, 2'd2, 32'h1111_0002, 5'h00),
                lane_stim(`MEM_ALU_LDB, 2'd2, 32'h2222_0002, 5'h00));
        add_row("ldbu_ldb_off3", 1'b1, lane_stim(`MEM_ALU_LDBU, 2'd3, 32'h1111_0003, 5'h00),
                lane_stim(`MEM_ALU_LDB, 2'd3, 32'h2222_0003, 5'h00));
        add_row("ldh_ldhu_off0", 1'b1, lane_stim(`MEM_ALU_LDH, 2'd0, 32'h3333_0000, 5'h00),
                lane_stim(`MEM_ALU_LDHU, 2'd0, 32'h4444_0000, 5'h00));
        add_row("ldhu_ldh_off2", 1'b1, lane_stim(`MEM_ALU_LDHU, 2'd2, 32'h3333_0002, 5'h00),
                lane_stim(`MEM_ALU_LDH, 2'd2, 32'h4444_0002, 5'h00));
        add_row("ldw_llw", 1'b1, lane_stim(`MEM_ALU_LDW, 2'd0, 32'h5555_0000, 5'h00),
                lane_stim(`MEM_ALU_LLW, 2'd0, 32'h6666_0000, 5'h00));
        add_row("ldh_odd", 1'b1, lane_stim(`MEM_ALU_LDH, 2'd1, 32'h7777_0001, 5'h00),
                lane_stim(OP_ADD, 2'd3, 32'h8888_0003, 5'h00));
        add_row("alu_no_dok", 1'b0, lane_stim(OP_ADD, 2'd2, 32'hcafe_0001, 5'h00),
                lane_stim(OP_OR, 2'd1, 32'hbeef_0002, 5'h00));
        add_row("ldw_wait", 1'b0, lane_stim(`MEM_ALU_LDW, 2'd0, 32'h9999_0000, 5'h00),
                lane_stim(OP_ADD, 2'd0, 32'h0123_4567, 5'h00));
        add_row("ldw_done", 1'b1, lane_stim(`MEM_ALU_LDW, 2'd0, 32'h9999_0000, 5'h00),
                lane_stim(OP_ADD, 2'd0, 32'h0123_4567, 5'h00));
        add_row("ldb_wait_l1", 1'b0, lane_stim(OP_OR, 2'd0, 32'h0f0f_0f0f, 5'h00),
                lane_stim(`MEM_ALU_LDB, 2'd3, 32'haaaa_0003, 5'h00));
        add_row("ldb_exc_l0", 1'b0, lane_stim(OP_OR, 2'd0, 32'h0f0f_0f0f, 5'h04),
                lane_stim(`MEM_ALU_LDB, 2'd3, 32'haaaa_0003, 5'h00));
        add_row("ldh_exc_l1", 1'b0, lane_stim(`MEM_ALU_LDH, 2'd2, 32'hbbbb_0002, 5'h00),
                lane_stim(OP_ADD, 2'd1, 32'h7654_3210, 5'h11));
        add_row("alu_exc_both", 1'b1, lane_stim(OP_ADD, 2'd1, 32'hdead_beef, 5'h1f),
                lane_stim(OP_OR, 2'd2, 32'hfeed_f00d, 5'h02));
        add_row("alu_plain", 1'b1, lane_stim(OP_OR, 2'd3, 32'h8000_0001, 5'h00),
                lane_stim(OP_ADD, 2'd0, 32'h7fff_fffe, 5'h00));
    endtask

    initial begin
        wait (table_built);
        #((rows.size() * 4 + 5) * 10);
        fail_stop("timeout: the run did not finish in the expected time");
    end

    initial begin
        mem_pkg::reg_write_t exp_w [`MEM_LANES];
        mem_pkg::commit_t    exp_c [`MEM_LANES];
        logic                any_wait;
        logic                any_exc;
        logic                exp_pause;
        row_t                r;

        rst_n            = 1'b0;
        lane_in          = '1;  // valid bundle held during reset
        dcache_read_data = '0;
        data_ok          = 1'b0;
        lfsr_state       = 32'ha12bf95a;
        build_table();
        table_built = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < `MEM_LANES; i++) begin
            check_bit($sformatf("reset wb_en%0d", i), 1'b0, wb_write.lane[i].en);
            check_bit($sformatf("reset valid%0d", i), 1'b0, commit_out.lane[i].valid);
        end

        foreach (rows[n]) begin
            r                = rows[n];
            any_wait         = 1'b0;
            any_exc          = 1'b0;
            dcache_read_data = lfsr_bits(32);
            data_ok          = r.dok;
            for (int i = 0; i < `MEM_LANES; i++) begin
                lane_in[i] = make_lane(r.lane[i]);
                exp_w[i]   = exp_wb(lane_in[i], dcache_read_data, r.dok);
                exp_c[i]   = exp_commit(lane_in[i]);
                any_wait   = any_wait | (is_load_op(r.lane[i].op) & !r.dok);
                any_exc    = any_exc | (|r.lane[i].exc);
            end
            exp_pause = any_wait && !any_exc;  // exception overrides the cache wait

            #2;
            check_bit($sformatf("%s pause_mem", r.name), exp_pause, pause_mem);
            for (int i = 0; i < `MEM_LANES; i++) begin
                check_wb($sformatf("%s pf_write%0d", r.name, i), lane_in[i].wr,
                         mem_pf_write[i]);
            end

            @(posedge clk);
            #1;
            for (int i = 0; i < `MEM_LANES; i++) begin
                if (exp_pause) begin
                    exp_w[i] = '0;  // bubble
                    exp_c[i] = '0;
                end
                check_wb($sformatf("%s wb%0d", r.name, i), exp_w[i], wb_write.lane[i]);
                check_commit($sformatf("%s commit%0d", r.name, i), exp_c[i],
                             commit_out.lane[i]);
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_stage (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  mem_pkg::lane_in_t   [`MEM_LANES-1:0]    lane_in,
    input  logic                [`MEM_XLEN-1:0]     dcache_read_data,
    input  logic                                    data_ok,
    output mem_pkg::reg_write_t [`MEM_LANES-1:0]    mem_pf_write,
    output logic                                    pause_mem,
    output mem_pkg::wb_bundle_t                     wb_write,
    output mem_pkg::commit_bundle_t                 commit_out
);

    logic [`MEM_LANES-1:0]   wait_data;
    logic [`MEM_LANES-1:0]   exc_lane;
    logic                    exc_any;
    mem_pkg::wb_bundle_t     wb_d;
    mem_pkg::commit_bundle_t commit_d;

    genvar i;
    generate
        for (i = 0; i < `MEM_LANES; i++) begin : g_lane
            assign mem_pf_write[i] = lane_in[i].wr;  // dispatcher bypass, raw exe data
            assign exc_lane[i]     = |lane_in[i].exc;

            mem_lane i_mem_lane (
                .lane         (lane_in[i]),
                .read_word    (dcache_read_data),
                .data_ok      (data_ok),
                .wait_data    (wait_data[i]),
                .wb_entry     (wb_d.lane[i]),
                .commit_entry (commit_d.lane[i])
            );
        end
    endgenerate

    assign exc_any   = |exc_lane;
    assign pause_mem = (|wait_data) && !exc_any;  // exception flushes, no need to wait

    mem_wb_reg #(
        .payload_t (mem_pkg::wb_bundle_t)
    ) i_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (pause_mem),
        .d     (wb_d),
        .q     (wb_write)
    );

    mem_wb_reg #(
        .payload_t (mem_pkg::commit_bundle_t)
    ) i_commit_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (pause_mem),
        .d     (commit_d),
        .q     (commit_out)
    );

    // pending exception must never hold the pipe on the cache
    a_no_pause_on_exc: assert property (
        @(posedge clk) disable iff (!rst_n)
        exc_any |-> !pause_mem
    ) else $error("pause_mem high with exception pending");

endmodule

// ==== hw/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (stall) begin
            q <= '0;  // bubble
        end else begin
            q <= d;
        end
    end

    a_bubble_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> (q == '0)
    ) else $error("stage register not empty after stalled edge");

endmodule

// ==== hw/mem_lane.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_lane (
    input  mem_pkg::lane_in_t    lane,
    input  logic [`MEM_XLEN-1:0] read_word,
    input  logic                 data_ok,
    output logic                 wait_data,
    output mem_pkg::reg_write_t  wb_entry,
    output mem_pkg::commit_t     commit_entry
);

    mem_pkg::load_kind_t  kind;
    logic                 is_load;
    logic [`MEM_XLEN-1:0] aligned;

    always_comb begin
        case (lane.aluop)
            `MEM_ALU_LDB:  kind = mem_pkg::LD_B;
            `MEM_ALU_LDBU: kind = mem_pkg::LD_BU;
            `MEM_ALU_LDH:  kind = mem_pkg::LD_H;
            `MEM_ALU_LDHU: kind = mem_pkg::LD_HU;
            `MEM_ALU_LDW:  kind = mem_pkg::LD_W;
            `MEM_ALU_LLW:  kind = mem_pkg::LD_W;  // ll.w reads like ld.w
            default:       kind = mem_pkg::LD_NONE;
        endcase
    end

    assign is_load   = (kind != mem_pkg::LD_NONE);
    assign wait_data = is_load && !data_ok;

    load_align i_load_align (
        .kind      (kind),
        .byte_off  (lane.mem_addr[1:0]),
        .read_word (read_word),
        .load_data (aligned)
    );

    assign wb_entry.en   = lane.wr.en;
    assign wb_entry.addr = lane.wr.addr;
    assign wb_entry.data = !is_load ? lane.wr.data :
                           data_ok  ? aligned      : '0;

    assign commit_entry.valid = lane.valid;
    assign commit_entry.pc    = lane.pc;
    assign commit_entry.addr  = lane.mem_addr;
    assign commit_entry.exc   = {lane.exc, 1'b0};  // no mem-stage exception yet
    assign commit_entry.cause = {lane.cause, `MEM_EXCEPTION_NOP};

    // stall request only ever comes from a real load opcode
    always_comb begin
        assert final (!wait_data || lane.aluop inside {`MEM_ALU_LDB, `MEM_ALU_LDBU,
                      `MEM_ALU_LDH, `MEM_ALU_LDHU, `MEM_ALU_LDW, `MEM_ALU_LLW})
        else $error("wait_data raised for non-load aluop %h", lane.aluop);
    end

endmodule

// ==== hw/load_align.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module load_align (
    input  mem_pkg::load_kind_t  kind,
    input  logic [1:0]           byte_off,
    input  logic [`MEM_XLEN-1:0] read_word,
    output logic [`MEM_XLEN-1:0] load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (byte_off)
            2'd0: byte_sel = read_word[7:0];
            2'd1: byte_sel = read_word[15:8];
            2'd2: byte_sel = read_word[23:16];
            default: byte_sel = read_word[31:24];
        endcase
    end

    assign half_sel = byte_off[1] ? read_word[31:16] : read_word[15:0];  // lane 2 or lane 0

    always_comb begin
        case (kind)
            mem_pkg::LD_B: begin
                load_data = {{(`MEM_XLEN-8){byte_sel[7]}}, byte_sel};
            end
            mem_pkg::LD_BU: begin
                load_data = {{(`MEM_XLEN-8){1'b0}}, byte_sel};
            end
            mem_pkg::LD_H: begin
                if (byte_off[0]) begin
                    load_data = '0;  // misaligned half
                end else begin
                    load_data = {{(`MEM_XLEN-16){half_sel[15]}}, half_sel};
                end
            end
            mem_pkg::LD_HU: begin
                if (byte_off[0]) begin
                    load_data = '0;
                end else begin
                    load_data = {{(`MEM_XLEN-16){1'b0}}, half_sel};
                end
            end
            mem_pkg::LD_W: begin
                load_data = read_word;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// ==== hw/mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,  // signed byte
        LD_BU   = 3'd2,
        LD_H    = 3'd3,  // signed half
        LD_HU   = 3'd4,
        LD_W    = 3'd5   // word, also ll.w
    } load_kind_t;

    typedef struct packed {
        logic                   en;
        logic [`MEM_REG_AW-1:0] addr;
        logic [`MEM_XLEN-1:0]   data;
    } reg_write_t;

    // one lane from execute
    typedef struct packed {
        logic                                        valid;
        logic [`MEM_XLEN-1:0]                        pc;
        logic [`MEM_ALUOP_W-1:0]                     aluop;
        logic [`MEM_XLEN-1:0]                        mem_addr;
        reg_write_t                                  wr;
        logic [`MEM_EXC_IN_W-1:0]                    exc;
        logic [`MEM_EXC_IN_W-1:0][`MEM_CAUSE_W-1:0]  cause;
    } lane_in_t;

    // one lane to commit control
    typedef struct packed {
        logic                                        valid;
        logic [`MEM_XLEN-1:0]                        pc;
        logic [`MEM_XLEN-1:0]                        addr;
        logic [`MEM_EXC_OUT_W-1:0]                   exc;
        logic [`MEM_EXC_OUT_W-1:0][`MEM_CAUSE_W-1:0] cause;
    } commit_t;

    typedef struct packed {
        reg_write_t [`MEM_LANES-1:0] lane;
    } wb_bundle_t;

    typedef struct packed {
        commit_t [`MEM_LANES-1:0] lane;
    } commit_bundle_t;

endpackage

// ==== hw/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// datapath and issue width
`define MEM_XLEN        32
`define MEM_LANES       2
`define MEM_REG_AW      5
`define MEM_ALUOP_W     8

// exception fields, this stage adds one flag and one cause
`define MEM_EXC_IN_W    5
`define MEM_EXC_OUT_W   6
`define MEM_CAUSE_W     7

// load opcodes as seen on aluop
`define MEM_ALU_LDB     8'h20
`define MEM_ALU_LDBU    8'h21
`define MEM_ALU_LDH     8'h22
`define MEM_ALU_LDHU    8'h23
`define MEM_ALU_LDW     8'h24
`define MEM_ALU_LLW     8'h25

// cause slot with nothing to report
`define MEM_EXCEPTION_NOP 7'h7f

`endif
